// ==== Bender.yml ====
package:
  name: psumBlock

sources:
  - include_dirs:
      - .
    files:
      - psumDataPkg.sv
      - psumCtrlPkg.sv
      - psumBank.sv
      - psumFrameRegs.sv
      - psumRouter.sv
      - psumBlock.sv
  - target: test
    include_dirs:
      - .
    files:
      - psumBlock_checker.sv
      - psumBlock_tb.sv

// ==== psumBank.sv ====
`timescale 1ns/1ps
`include "psum_settings.svh"

module psumBank #(
    parameter int DEPTH      = `PSUM_DEPTH,
    parameter int DATA_WIDTH = `PSUM_WIDTH
) (
    input  logic                  clk,
    input  logic                  wrEn,
    input  psumDataPkg::psumAddr  wrAddr,
    input  logic [DATA_WIDTH-1:0] wrData,
    input  logic                  rdEn,
    input  psumDataPkg::psumAddr  rdAddr,
    output logic [DATA_WIDTH-1:0] rdData
);

    // storage, contents undefined after power up
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // ====================
    // write port
    // ====================

    // address space is wider than the tile
    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr < DEPTH)) begin
            mem[wrAddr] <= wrData;
        end
    end

    // ====================
    // read port
    // ====================

    // one cycle latency, output holds between reads
    // same-address write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== psumBlock.f ====
+incdir+.
psumDataPkg.sv
psumCtrlPkg.sv
psumBank.sv
psumFrameRegs.sv
psumRouter.sv
psumBlock.sv
psumBlock_checker.sv
psumBlock_tb.sv

// ==== psumBlock.sv ====
`timescale 1ns/1ps
`include "psum_settings.svh"

module psumBlock #(
    localparam int NUM_BANKS = `NUM_COLS + 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  psumCtrlPkg::apbReq   apbIn,
    output psumCtrlPkg::apbRsp   apbOut,
    input  psumDataPkg::colReq   colIn  [`NUM_COLS],
    output psumDataPkg::colRsp   colOut [`NUM_COLS],
    output logic                 poolEn,
    input  logic                 poolRdEn,
    input  psumDataPkg::psumAddr poolRdAddr,
    output psumDataPkg::psumData poolData
);

    // frame state from the register block
    psumCtrlPkg::frameCfg cfg;

    // router to bank requests and back
    psumDataPkg::bankReq  bankReqs   [NUM_BANKS];
    psumDataPkg::psumData bankRdData [NUM_BANKS];

    // ====================
    // frame control
    // ====================

    psumFrameRegs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .apbIn  (apbIn),
        .apbOut (apbOut),
        .cfg    (cfg),
        .poolEn (poolEn)
    );

    // ====================
    // bank routing
    // ====================

    psumRouter u_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .colIn      (colIn),
        .colOut     (colOut),
        .poolRdEn   (poolRdEn),
        .poolRdAddr (poolRdAddr),
        .poolData   (poolData),
        .bankOut    (bankReqs),
        .bankData   (bankRdData)
    );

    // ====================
    // storage
    // ====================

    // banks 0 and 1 per column, 2 and 3 ping-pong for column 2
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
        psumBank #(
            .DEPTH      (`PSUM_DEPTH),
            .DATA_WIDTH (`PSUM_WIDTH)
        ) u_bank (
            .clk    (clk),
            .wrEn   (bankReqs[b].wrEn),
            .wrAddr (bankReqs[b].wrAddr),
            .wrData (bankReqs[b].wrData),
            .rdEn   (bankReqs[b].rdEn),
            .rdAddr (bankReqs[b].rdAddr),
            .rdData (bankRdData[b])
        );
    end

endmodule

// ==== psumBlock_checker.sv ====
`timescale 1ns/1ps

module psumBlock_checker (
    input logic                 clk,
    input logic                 rst_n,
    input psumCtrlPkg::apbReq   apbIn,
    input psumCtrlPkg::apbRsp   apbOut,
    input logic                 poolEn
);

    // failed assertions so far
    int failCount = 0;

    // ====================
    // APB
    // ====================

    // zero wait state slave
    a_pready: assert property (@(posedge clk) disable iff (!rst_n) apbOut.pready)
        else begin
            failCount++;
            $error("pready went low");
        end

    // error response only with psel and penable both high
    a_slverrPhase: assert property (@(posedge clk) disable iff (!rst_n)
        apbOut.pslverr |-> (apbIn.psel && apbIn.penable))
        else begin
            failCount++;
            $error("pslverr outside the access phase");
        end

    // ====================
    // pool start
    // ====================

    // single-cycle pulse
    a_poolPulse: assert property (@(posedge clk) disable iff (!rst_n)
        poolEn |=> !poolEn)
        else begin
            failCount++;
            $error("poolEn high for two cycles");
        end

endmodule

bind psumBlock psumBlock_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .apbIn  (apbIn),
    .apbOut (apbOut),
    .poolEn (poolEn)
);

// ==== psumBlock_input.txt ====
# op col addr data expected, fields in hex, a dash marks an unused field
# ops T AW AR AE CW CR CB PR PW, data RND is LFSR filler, expected CALC uses written data
T reset_values - - -
AR - 0 - 3
AR - 4 - 1
AE - 8 - 0
T first_frame_chain - - -
CW 0 05 11111 NONE
CW 1 05 22222 NONE
CW 2 05 33333 NONE
CR 0 05 - 0
CR 1 05 - 0
CR 2 05 - 0
T normal_block - - -
AW - 0 2 NONE
PW - - - 0
CW 0 20 RND NONE
CW 0 21 RND NONE
CW 0 22 RND NONE
CW 1 20 RND NONE
CW 1 21 RND NONE
CW 1 22 RND NONE
CW 2 20 RND NONE
CW 2 21 RND NONE
CW 2 22 RND NONE
CB 0 20 3 CALC
CB 1 20 3 CALC
CB 2 20 3 CALC
CR 0 05 - 11111
T ping_pong - - -
CW 2 10 0AAAA NONE
CR 2 10 - 0AAAA
AW - 0 0 NONE
CW 2 10 0BBBB NONE
CR 2 10 - 0BBBB
PR - 10 - 0AAAA
AW - 0 2 NONE
CW 2 10 0CCCC NONE
CR 2 10 - 0CCCC
PR - 10 - 0BBBB
T later_frame_chain - - -
AR - 4 - 0
CW 0 30 RND NONE
CW 1 30 RND NONE
AW - 0 0 NONE
CW 2 30 RND NONE
CW 1 31 7FFFF NONE
CW 2 31 00001 NONE
AW - 0 3 NONE
CR 0 30 - 0
CR 1 30 - CALC
CR 2 30 - CALC
CR 2 31 - 80000
T pool_start - - -
AW - 0 2 NONE
PW - - - 1
PR - 10 - 0BBBB

// ==== psumBlock_tb.sv ====
`timescale 1ns/1ps
`include "psum_settings.svh"

module psumBlock_tb;

    localparam int TOK_W        = 8 * 24;
    localparam int LINE_W       = 8 * 128;
    localparam int POOL_TIMEOUT = 16;

    logic                 clk;
    logic                 rst_n;
    psumCtrlPkg::apbReq   apbIn;
    psumCtrlPkg::apbRsp   apbOut;
    psumDataPkg::colReq   colIn  [`NUM_COLS];
    psumDataPkg::colRsp   colOut [`NUM_COLS];
    logic                 poolEn;
    logic                 poolRdEn;
    psumDataPkg::psumAddr poolRdAddr;
    psumDataPkg::psumData poolData;

    // reference copy of the four banks
    psumDataPkg::psumData shadow [4][256];
    // frame state as left by the CTRL writes
    logic mFirstBlock;
    logic mEvenFrame;
    logic mFirstFrame;

    logic [31:0]      lfsrState;
    int               checkCount;
    int               errorCount;
    int               testCount;
    int               testErrStart;
    logic [TOK_W-1:0] testName;
    logic             timedOut;

    psumBlock u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apbIn      (apbIn),
        .apbOut     (apbOut),
        .colIn      (colIn),
        .colOut     (colOut),
        .poolEn     (poolEn),
        .poolRdEn   (poolRdEn),
        .poolRdAddr (poolRdAddr),
        .poolData   (poolData)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // reference model
    // ====================

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit taken
    function automatic psumDataPkg::psumData randomPsum();
        psumDataPkg::psumData v;
        for (int i = 0; i < `PSUM_WIDTH; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v[i] = lfsrState[0];
        end
        return v;
    endfunction

    // banks 0/1 fixed, column 2 follows frame parity
    function automatic int writeBank(input int col);
        if (col < `NUM_COLS - 1)
            return col;
        return mEvenFrame ? 2 : 3;
    endfunction

    // ping-pong bank column 2 leaves alone
    function automatic int idleBank();
        return mEvenFrame ? 3 : 2;
    endfunction

    function automatic psumDataPkg::psumData expectedCol(input int col, input int addr);
        psumDataPkg::psumData sum;
        if (!mFirstBlock)
            return shadow[writeBank(col)][addr];
        // chain head, or nothing to accumulate yet
        if (col == 0 || mFirstFrame)
            return '0;
        if (col == 1)
            return shadow[0][addr];
        // wraps at the partial-sum width
        sum = shadow[1][addr] + shadow[idleBank()][addr];
        return sum;
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", sigName, got, exp);
            errorCount++;
        end
    endtask

    // ====================
    // bus tasks
    // ====================

    task automatic apbWrite(input int offset, input logic [31:0] data);
        @(negedge clk);
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = 1'b1;
        apbIn.paddr   = psumCtrlPkg::apbAddr'(offset);
        apbIn.pwdata  = data;
        @(negedge clk);
        apbIn.penable = 1'b1;
        @(negedge clk);
        apbIn = '0;
    endtask

    // sampled while still in the access phase
    task automatic apbRead(input int offset, output logic [31:0] data, output logic err);
        @(negedge clk);
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = 1'b0;
        apbIn.paddr   = psumCtrlPkg::apbAddr'(offset);
        @(negedge clk);
        apbIn.penable = 1'b1;
        @(negedge clk);
        data  = apbOut.prdata;
        err   = apbOut.pslverr;
        apbIn = '0;
    endtask

    task automatic colWrite(input int col, input int addr, input psumDataPkg::psumData data);
        @(negedge clk);
        colIn[col].wrEn   = 1'b1;
        colIn[col].wrAddr = psumDataPkg::psumAddr'(addr);
        colIn[col].wrData = data;
        @(negedge clk);
        colIn[col].wrEn = 1'b0;
    endtask

    task automatic colRead(input int col, input int addr, output psumDataPkg::psumData data);
        @(negedge clk);
        colIn[col].rdEn   = 1'b1;
        colIn[col].rdAddr = psumDataPkg::psumAddr'(addr);
        @(negedge clk);
        data = colOut[col].rdData;
        colIn[col].rdEn = 1'b0;
    endtask

    // one read per cycle, data trails the address by one cycle
    task automatic colReadBurst(input int col, input int addr, input int count);
        psumDataPkg::psumData got;
        @(negedge clk);
        colIn[col].rdEn   = 1'b1;
        colIn[col].rdAddr = psumDataPkg::psumAddr'(addr);
        for (int i = 1; i <= count; i++) begin
            @(negedge clk);
            got = colOut[col].rdData;
            colIn[col].rdEn   = (i < count);
            colIn[col].rdAddr = psumDataPkg::psumAddr'(addr + i);
            checkValue($sformatf("colOut[%0d].rdData", col), $unsigned(got),
                       $unsigned(expectedCol(col, addr + i - 1)));
        end
    endtask

    task automatic poolRead(input int addr, output psumDataPkg::psumData data);
        @(negedge clk);
        poolRdEn   = 1'b1;
        poolRdAddr = psumDataPkg::psumAddr'(addr);
        @(negedge clk);
        data     = poolData;
        poolRdEn = 1'b0;
    endtask

    task automatic checkPoolPulse(input logic expectPulse);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        if (expectPulse) begin
            // bounded wait for the pulse
            while (!poolEn && waited < POOL_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!poolEn) begin
                $display("ERROR: no poolEn pulse within %0d cycles", POOL_TIMEOUT);
                errorCount++;
                timedOut = 1'b1;
            end else begin
                // single cycle only
                @(negedge clk);
                checkValue("poolEn", poolEn, 0);
            end
        end else begin
            // quiet window
            while (waited < POOL_TIMEOUT) begin
                seen += poolEn;
                @(negedge clk);
                waited++;
            end
            checkValue("poolEn pulse count", seen, 0);
        end
    endtask

    // ====================
    // stimulus file
    // ====================

    task automatic finishTest();
        if (testCount > 0) begin
            if (errorCount == testErrStart)
                $display("test %0s: ok", testName);
            else
                $display("test %0s: %0d errors", testName, errorCount - testErrStart);
        end
    endtask

    task automatic runLine(input logic [LINE_W-1:0] line);
        logic [TOK_W-1:0]     opTok;
        logic [TOK_W-1:0]     colTok;
        logic [TOK_W-1:0]     addrTok;
        logic [TOK_W-1:0]     dataTok;
        logic [TOK_W-1:0]     expTok;
        int                   n;
        int                   col;
        int                   addr;
        logic [31:0]          dataVal;
        logic [31:0]          expVal;
        logic [31:0]          rdata;
        logic                 err;
        psumDataPkg::psumData wrData;
        psumDataPkg::psumData got;
        psumDataPkg::psumData expPsum;

        n = $sscanf(line, "%s %s %s %s %s", opTok, colTok, addrTok, dataTok, expTok);
        // blank line or comment
        if (n < 1 || opTok == "#")
            return;
        if (n != 5) begin
            $display("ERROR: stimulus line does not have five fields");
            errorCount++;
            return;
        end
        if (opTok == "T") begin
            finishTest();
            testName     = colTok;
            testErrStart = errorCount;
            testCount++;
            return;
        end

        // dash fields leave the defaults
        col     = 0;
        addr    = 0;
        dataVal = '0;
        expVal  = '0;
        void'($sscanf(colTok, "%d", col));
        void'($sscanf(addrTok, "%h", addr));
        void'($sscanf(dataTok, "%h", dataVal));
        void'($sscanf(expTok, "%h", expVal));

        case (opTok)
            "AW": begin
                apbWrite(addr, dataVal);
                if (addr == `REG_CTRL) begin
                    mFirstBlock = dataVal[0];
                    mEvenFrame  = dataVal[1];
                    // odd frame ends the first frame for good
                    if (!dataVal[1])
                        mFirstFrame = 1'b0;
                end
            end
            "AR", "AE": begin
                apbRead(addr, rdata, err);
                checkValue("apbOut.prdata", rdata, expVal);
                checkValue("apbOut.pslverr", err, (opTok == "AE"));
            end
            "CW": begin
                wrData = (dataTok == "RND") ? randomPsum() : dataVal[`PSUM_WIDTH-1:0];
                colWrite(col, addr, wrData);
                shadow[writeBank(col)][addr] = wrData;
            end
            "CR": begin
                // routing of the request cycle
                expPsum = (expTok == "CALC") ? expectedCol(col, addr)
                                             : expVal[`PSUM_WIDTH-1:0];
                colRead(col, addr, got);
                checkValue($sformatf("colOut[%0d].rdData", col),
                           $unsigned(got), $unsigned(expPsum));
            end
            "CB": colReadBurst(col, addr, dataVal);
            "PR": begin
                expPsum = (expTok == "CALC") ? shadow[idleBank()][addr]
                                             : expVal[`PSUM_WIDTH-1:0];
                poolRead(addr, got);
                checkValue("poolData", $unsigned(got), $unsigned(expPsum));
            end
            "PW": checkPoolPulse(expVal[0]);
            default: begin
                $display("ERROR: unknown operation in stimulus file");
                errorCount++;
            end
        endcase
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        int               fd;
        logic [LINE_W-1:0] line;

        rst_n       = 1'b0;
        apbIn       = '0;
        poolRdEn    = 1'b0;
        poolRdAddr  = '0;
        foreach (colIn[c])
            colIn[c] = '0;
        mFirstBlock  = 1'b1;
        mEvenFrame   = 1'b1;
        mFirstFrame  = 1'b1;
        lfsrState    = 32'h371e;
        checkCount   = 0;
        errorCount   = 0;
        testCount    = 0;
        testErrStart = 0;
        testName     = '0;
        timedOut     = 1'b0;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("psumBlock_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file psumBlock_input.txt");
            errorCount++;
        end else begin
            line = '0;
            while (!timedOut && $fgets(line, fd) != 0) begin
                runLine(line);
                line = '0;
            end
            $fclose(fd);
        end
        finishTest();

        // bound assertions add their own failures
        errorCount += u_dut.u_checker.failCount;
        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== psumCtrlPkg.sv ====
`include "psum_settings.svh"

package psumCtrlPkg;

    // ====================
    // APB bus
    // ====================

    typedef logic [`APB_ADDR_WIDTH-1:0] apbAddr;
    typedef logic [`APB_DATA_WIDTH-1:0] apbData;

    // master to slave
    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        apbAddr paddr;
        apbData pwdata;
    } apbReq;

    // slave to master
    typedef struct packed {
        apbData prdata;
        logic   pready;
        logic   pslverr;
    } apbRsp;

    // ====================
    // frame state
    // ====================

    // pingSel high means column 2 writes bank 3
    // and the pool drains bank 2
    typedef struct packed {
        logic firstBlock;
        logic firstFrame;
        logic pingSel;
    } frameCfg;

endpackage

// ==== psumDataPkg.sv ====
`include "psum_settings.svh"

package psumDataPkg;

    // ====================
    // scalar types
    // ====================

    // one partial sum, wraps on overflow
    typedef logic signed [`PSUM_WIDTH-1:0] psumData;

    // word address inside one bank
    typedef logic [`PSUM_ADDR_WIDTH-1:0] psumAddr;

    // ====================
    // column side
    // ====================

    // write and read in the same cycle are allowed
    typedef struct packed {
        logic    wrEn;
        psumAddr wrAddr;
        psumData wrData;
        logic    rdEn;
        psumAddr rdAddr;
    } colReq;

    // valid the cycle after rdEn
    typedef struct packed {
        psumData rdData;
    } colRsp;

    // bank side, same layout as a column request
    typedef struct packed {
        logic    wrEn;
        psumAddr wrAddr;
        psumData wrData;
        logic    rdEn;
        psumAddr rdAddr;
    } bankReq;

endpackage

// ==== psumFrameRegs.sv ====
`timescale 1ns/1ps
`include "psum_settings.svh"

module psumFrameRegs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  psumCtrlPkg::apbReq   apbIn,
    output psumCtrlPkg::apbRsp   apbOut,
    output psumCtrlPkg::frameCfg cfg,
    output logic                 poolEn
);

    // access phase of a transfer
    logic accPhase;
    // offset decode
    logic selCtrl;
    logic selStatus;
    // CTRL write strobe
    logic ctrlWr;

    // frame controls held in CTRL
    logic firstBlock;
    logic evenFrame;
    // sticky until the first odd frame
    logic firstFrame;
    // firstBlock one cycle late, for edge detect
    logic firstBlockQ;

    // ====================
    // APB decode
    // ====================

    // setup is psel alone, access adds penable
    assign accPhase  = apbIn.psel & apbIn.penable;
    assign selCtrl   = (apbIn.paddr == psumCtrlPkg::apbAddr'(`REG_CTRL));
    assign selStatus = (apbIn.paddr == psumCtrlPkg::apbAddr'(`REG_STATUS));

    // STATUS ignores writes, no error either
    assign ctrlWr = accPhase & apbIn.pwrite & selCtrl;

    // zero wait state slave
    always_comb begin
        apbOut.prdata  = '0;
        apbOut.pready  = 1'b1;
        apbOut.pslverr = accPhase & ~(selCtrl | selStatus);
        if (selCtrl) begin
            apbOut.prdata[0] = firstBlock;
            apbOut.prdata[1] = evenFrame;
        end else if (selStatus) begin
            apbOut.prdata[0] = firstFrame;
        end
    end

    // ====================
    // frame registers
    // ====================

    // takes effect at the edge closing the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            firstBlock <= 1'b1;
            evenFrame  <= 1'b1;
        end else if (ctrlWr) begin
            firstBlock <= apbIn.pwdata[0];
            evenFrame  <= apbIn.pwdata[1];
        end
    end

    // first odd frame ends the first-frame period for good
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            firstFrame <= 1'b1;
        end else if (!evenFrame) begin
            firstFrame <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            firstBlockQ <= 1'b1;
        end else begin
            firstBlockQ <= firstBlock;
        end
    end

    // ====================
    // outputs
    // ====================

    // column 2 alternates ping-pong banks with frame parity
    assign cfg = '{
        firstBlock: firstBlock,
        firstFrame: firstFrame,
        pingSel:    ~evenFrame
    };

    // falling firstBlock means last frame's bank is complete
    // nothing to pool before the first frame is done
    assign poolEn = firstBlockQ & ~firstBlock & ~firstFrame;

endmodule

// ==== psumRouter.sv ====
`timescale 1ns/1ps
`include "psum_settings.svh"

module psumRouter #(
    localparam int NUM_BANKS = `NUM_COLS + 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  psumCtrlPkg::frameCfg cfg,
    input  psumDataPkg::colReq   colIn    [`NUM_COLS],
    output psumDataPkg::colRsp   colOut   [`NUM_COLS],
    input  logic                 poolRdEn,
    input  psumDataPkg::psumAddr poolRdAddr,
    output psumDataPkg::psumData poolData,
    output psumDataPkg::bankReq  bankOut  [NUM_BANKS],
    input  psumDataPkg::psumData bankData [NUM_BANKS]
);

    typedef logic [$clog2(NUM_BANKS)-1:0] bankIdx;

    // last column owns the ping-pong pair
    localparam int LAST_COL = `NUM_COLS - 1;
    // pair sits after the single-owner banks
    localparam bankIdx PING_A = bankIdx'(`NUM_COLS - 1);
    localparam bankIdx PING_B = bankIdx'(`NUM_COLS);

    // request-cycle bank selection
    bankIdx wrPing;
    bankIdx poolPing;
    // chained reads only after the first frame
    logic   chainRd;
    logic   anyRd;

    // frame state of the read in flight
    psumCtrlPkg::frameCfg cfgQ;
    bankIdx               wrPingQ;
    bankIdx               poolPingQ;
    psumDataPkg::psumData chainSum;

    // ====================
    // request side
    // ====================

    assign wrPing   = cfg.pingSel ? PING_B : PING_A;
    assign poolPing = cfg.pingSel ? PING_A : PING_B;
    assign chainRd  = ~cfg.firstFrame;

    always_comb begin
        // unused banks get no enables
        bankOut = '{default: '0};

        // writes never move with firstBlock
        for (int c = 0; c < LAST_COL; c++) begin
            bankOut[c].wrEn   = colIn[c].wrEn;
            bankOut[c].wrAddr = colIn[c].wrAddr;
            bankOut[c].wrData = colIn[c].wrData;
        end
        bankOut[wrPing].wrEn   = colIn[LAST_COL].wrEn;
        bankOut[wrPing].wrAddr = colIn[LAST_COL].wrAddr;
        bankOut[wrPing].wrData = colIn[LAST_COL].wrData;

        if (!cfg.firstBlock) begin
            // plain mode, each column reads its own bank
            for (int c = 0; c < LAST_COL; c++) begin
                bankOut[c].rdEn   = colIn[c].rdEn;
                bankOut[c].rdAddr = colIn[c].rdAddr;
            end
            bankOut[wrPing].rdEn   = colIn[LAST_COL].rdEn;
            bankOut[wrPing].rdAddr = colIn[LAST_COL].rdAddr;
            // pool drains the bank column 2 left behind
            bankOut[poolPing].rdEn   = poolRdEn;
            bankOut[poolPing].rdAddr = poolRdAddr;
        end else begin
            // first block, reads shift one column down the chain
            // bank c now serves column c+1
            for (int c = 0; c < LAST_COL; c++) begin
                bankOut[c].rdEn   = colIn[c+1].rdEn & chainRd;
                bankOut[c].rdAddr = colIn[c+1].rdAddr;
            end
            // previous frame's sums join column 2's chain
            // pool is locked out of this port
            bankOut[poolPing].rdEn   = colIn[LAST_COL].rdEn & chainRd;
            bankOut[poolPing].rdAddr = colIn[LAST_COL].rdAddr;
        end
    end

    // ====================
    // read tracking
    // ====================

    always_comb begin
        anyRd = poolRdEn;
        for (int c = 0; c < `NUM_COLS; c++) begin
            anyRd = anyRd | colIn[c].rdEn;
        end
    end

    // snapshot on every read, so a CTRL change cannot
    // reroute data already on its way back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgQ <= '{firstBlock: 1'b1, firstFrame: 1'b1, pingSel: 1'b0};
        end else if (anyRd) begin
            cfgQ <= cfg;
        end
    end

    // ====================
    // response side
    // ====================

    assign wrPingQ   = cfgQ.pingSel ? PING_B : PING_A;
    assign poolPingQ = cfgQ.pingSel ? PING_A : PING_B;

    // signed add, wraps at PSUM_WIDTH
    assign chainSum = bankData[LAST_COL-1] + bankData[poolPingQ];

    always_comb begin
        if (!cfgQ.firstBlock) begin
            for (int c = 0; c < LAST_COL; c++) begin
                colOut[c].rdData = bankData[c];
            end
            colOut[LAST_COL].rdData = bankData[wrPingQ];
        end else begin
            // head of the chain starts from zero
            colOut[0].rdData = '0;
            for (int c = 1; c < LAST_COL; c++) begin
                colOut[c].rdData = cfgQ.firstFrame ? '0 : bankData[c-1];
            end
            colOut[LAST_COL].rdData = cfgQ.firstFrame ? '0 : chainSum;
        end
    end

    // only meaningful in plain mode
    assign poolData = bankData[poolPingQ];

endmodule

// ==== psum_settings.svh ====
`ifndef PSUM_SETTINGS_SVH
`define PSUM_SETTINGS_SVH

// ====================
// partial-sum storage
// ====================

// signed partial sum
`define PSUM_WIDTH      20
// one 14x14 output tile per bank
`define PSUM_DEPTH      196
`define PSUM_ADDR_WIDTH 8

// processing-element columns sharing the block
`define NUM_COLS        3

// ====================
// APB register map
// ====================

`define APB_ADDR_WIDTH  4
`define APB_DATA_WIDTH  32

// frame controls, read/write
`define REG_CTRL        0
// frame status, read only
`define REG_STATUS      4

`endif
